//--- tb.f
logic/sink_pkg.sv
logic/sink_addr_gen.sv
logic/sink_addr_fifo.sv
logic/sink_store_align.sv
logic/sink_ctrl.sv
logic/sink_streamer.sv
bench/tb_clock.sv
bench/tb_sink_checker.sv
bench/tb_sink.sv

//--- run.sh
#!/bin/sh
# build the store streamer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_sink -Mdir build -f tb.f

# the simulation keeps going past assertion errors so the bench can report them
out=$(./build/Vtb_sink +verilator+error+limit+1000) || true
printf '%s\n' "$out"

# pass only when the bench printed its pass line
printf '%s\n' "$out" | grep -qx "TEST PASS"

//--- bench/tb_sink.sv
// testbench for the store streamer, aligned, misaligned and back-pressured jobs
`timescale 1ns/10ps

module tb_sink;

  localparam int unsigned TOTAL_WORDS  = 8 + 6 + 32 + 5;          // all jobs
  localparam int unsigned WATCHDOG_CYC = TOTAL_WORDS * 40 + 2000;
  localparam logic [31:0] LFSR_SEED    = 32'd86429;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;           // x^32+x^22+x^2+x+1

  logic                  clk, rst_n;
  logic                  clear, enable;
  logic                  strm_valid, strm_ready;
  sink_pkg::strm_beat_t  strm;
  logic                  mem_valid, mem_gnt;
  sink_pkg::mem_store_t  mem;
  sink_pkg::sink_ctrl_t  ctrl;
  sink_pkg::sink_flags_t flags;

  logic [31:0]          lfsr_q;
  sink_pkg::strm_beat_t beats_q [$];   // words not yet taken by the DUT
  sink_pkg::mem_store_t exp_q   [$];   // stores in expected order
  int unsigned          err_cnt, test_err, tests_run, tests_failed;
  int unsigned          cyc, last_gnt_cyc, stores_seen;

  tb_clock u_tb_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  sink_streamer u_sink_streamer (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .clear_i      ( clear      ),
    .enable_i     ( enable     ),
    .strm_valid_i ( strm_valid ),
    .strm_i       ( strm       ),
    .strm_ready_o ( strm_ready ),
    .mem_valid_o  ( mem_valid  ),
    .mem_o        ( mem        ),
    .mem_gnt_i    ( mem_gnt    ),
    .ctrl_i       ( ctrl       ),
    .flags_o      ( flags      )
  );

  bind sink_streamer tb_sink_checker u_sink_checker (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .strm_ready_o ( strm_ready_o ),
    .mem_valid_o  ( mem_valid_o  ),
    .mem_o        ( mem_o        ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .flags_o      ( flags_o      )
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);   // right shifting galois form
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_hex(input string sig, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%h exp 0x%h", sig, got, exp);
      test_err++;
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    if (!ok) begin
      $display("%s", what);
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d stores, %0d errors", name, stores_seen, test_err);
    tests_run++;
    if (test_err != 0) tests_failed++;
    err_cnt += test_err;
  endtask

  // words and expected stores from base, stride and the byte offset rule
  task automatic build_job(input logic [31:0] base, input logic [15:0] stride,
                           input int unsigned len, input logic rand_strb);
    logic [31:0]          a, w, s;
    int unsigned          offs;
    sink_pkg::strm_beat_t b;
    sink_pkg::mem_store_t e;
    beats_q.delete();
    exp_q.delete();
    for (int unsigned i = 0; i < len; i++) begin
      a = base + i * 32'(stride);
      take_bits(32, w);
      if (rand_strb) take_bits(4, s);
      else s = 32'h0000_000f;
      offs   = int'(a[1:0]);
      b.data = w;
      b.strb = s[3:0];
      e.addr = {a[31:2], 2'b00};
      e.data = {32'h0, w} << (8 * offs);   // one byte lane per offset step
      e.be   = {4'h0, s[3:0]} << offs;
      beats_q.push_back(b);
      exp_q.push_back(e);
    end
  endtask

  task automatic run_job(input string name, input logic [31:0] base, input logic [15:0] stride,
                         input int unsigned len, input logic rand_strb, input logic rand_hs);
    logic [31:0]          r;
    logic                 beat_on;
    logic                 done_seen;
    int unsigned          start_cyc;
    sink_pkg::mem_store_t e;
    test_err    = 0;
    stores_seen = 0;
    beat_on     = 1'b0;
    done_seen   = 1'b0;
    build_job(base, stride, len, rand_strb);
    ctrl.cfg.base_addr = base;            // held for the whole job
    ctrl.cfg.stride    = stride;
    ctrl.cfg.tot_len   = 16'(len);
    start_cyc          = cyc;
    while (!done_seen) begin
      @(negedge clk);
      ctrl.req_start = (cyc == start_cyc);   // single cycle request
      if (!beat_on) strm_valid = 1'b0;
      if (!beat_on && beats_q.size() > 0) begin
        take_bits(2, r);
        if (!rand_hs || r[1:0] != 2'b00) begin   // gap about one cycle in four
          strm       = beats_q[0];
          strm_valid = 1'b1;
          beat_on    = 1'b1;
        end
      end
      if (rand_hs) begin
        take_bits(1, r);
        mem_gnt = r[0];
      end else begin
        mem_gnt = 1'b1;
      end
      #1;   // settled until the next rising edge
      if (cyc == start_cyc) check_cond(flags.ready_start, "ready_start low before the start");
      if (cyc == start_cyc + 1) begin
        check_cond(!flags.ready_start, "ready_start still high after the start was taken");
        check_cond(!flags.gen_done, "gen_done high before any address was issued");
      end
      if (mem_valid && mem_gnt) begin
        if (exp_q.size() == 0) begin
          check_cond(1'b0, "store granted beyond the end of the job");
        end else begin
          e = exp_q.pop_front();
          check_hex("mem_o.addr", 64'(mem.addr), 64'(e.addr));
          check_hex("mem_o.data", mem.data, e.data);
          check_hex("mem_o.be", 64'(mem.be), 64'(e.be));
          if (exp_q.size() == 0) begin
            // every address is out by the time the last store goes
            check_cond(flags.gen_done, "gen_done low at the last store");
          end
        end
        stores_seen++;
        last_gnt_cyc = cyc;
      end
      if (strm_valid && strm_ready) begin
        void'(beats_q.pop_front());
        beat_on = 1'b0;                  // dropped at the next falling edge
      end
      if (flags.done) begin
        done_seen = 1'b1;
        check_cond(stores_seen == len, "done raised before every store was granted");
        check_cond(cyc == last_gnt_cyc + 1, "done did not follow the last grant by one cycle");
        check_cond(flags.ready_start, "ready_start low in the done cycle");
      end
      cyc++;
    end
    @(negedge clk);
    strm_valid = 1'b0;
    mem_gnt    = 1'b0;
    #1;
    check_cond(!flags.done, "done held for more than one cycle");
    check_cond(exp_q.size() == 0 && beats_q.size() == 0, "job ended with words left over");
    cyc++;
    end_test(name);
  endtask

  initial begin
    int unsigned chk_fails;
    clear        = 1'b0;
    enable       = 1'b1;
    strm_valid   = 1'b0;
    strm         = '0;
    mem_gnt      = 1'b0;
    ctrl         = '0;
    lfsr_q       = LFSR_SEED;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc          = 0;
    last_gnt_cyc = 0;
    stores_seen  = 0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    #1;
    test_err = 0;
    check_hex("flags_o.ready_start", 64'(flags.ready_start), 64'h1);
    check_hex("flags_o.done", 64'(flags.done), 64'h0);
    check_hex("flags_o.gen_done", 64'(flags.gen_done), 64'h0);
    check_hex("mem_valid_o", 64'(mem_valid), 64'h0);
    check_hex("strm_ready_o", 64'(strm_ready), 64'h0);
    cyc++;
    end_test("reset");

    run_job("aligned", 32'h0000_0100, 16'd4, 8, 1'b0, 1'b0);
    run_job("misaligned", 32'h0000_0203, 16'd8, 6, 1'b1, 1'b0);
    run_job("backpressure", 32'h0000_4001, 16'd6, 32, 1'b1, 1'b1);
    run_job("restart", 32'h0000_7ffe, 16'd3, 5, 1'b1, 1'b1);   // second start after done

    chk_fails = u_sink_streamer.u_sink_checker.fail_cnt;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, chk_fails);
    if (err_cnt == 0 && chk_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // bound from the summed job lengths
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired, a job did not complete in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- bench/tb_sink_checker.sv
// bound checker on the streamer ports, idle request, store stability, done pulse and reset state
`timescale 1ns/10ps

module tb_sink_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  strm_ready_o,
  input logic                  mem_valid_o,
  input sink_pkg::mem_store_t  mem_o,
  input logic                  mem_gnt_i,
  input sink_pkg::sink_flags_t flags_o
);

  int unsigned fail_cnt = 0;   // read by the bench at the end

  // first edge out of reset sees the idle values
  reset_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> flags_o.ready_start && !flags_o.done && !flags_o.gen_done &&
                      !mem_valid_o && !strm_ready_o)
    else begin
      $error("streamer not idle right after reset");
      fail_cnt++;
    end

  // idle controller never requests
  idle_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_o.ready_start |-> !mem_valid_o)
    else begin
      $error("store request while ready_start is high");
      fail_cnt++;
    end

  store_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_o && !mem_gnt_i |=> mem_valid_o && $stable(mem_o))
    else begin
      $error("store request changed or dropped without a grant");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_o.done |-> flags_o.ready_start ##1 !flags_o.done)
    else begin
      $error("done longer than one cycle or raised while busy");
      fail_cnt++;
    end

endmodule

//--- bench/tb_clock.sv
// testbench clock and reset source, 20 ns period with reset held for 10 cycles
`timescale 1ns/10ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HALF_PERIOD = 10;   // ns
  localparam int unsigned RST_CYCLES  = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;                          // asserted from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;                          // release away from the active edge
  end

endmodule

//--- logic/sink_streamer.sv
// store streamer top, address generation, buffering, alignment and control
`timescale 1ns/10ps

module sink_streamer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  enable_i,
  // stream in
  input  logic                  strm_valid_i,
  input  sink_pkg::strm_beat_t  strm_i,
  output logic                  strm_ready_o,
  // memory store port
  output logic                  mem_valid_o,
  output sink_pkg::mem_store_t  mem_o,
  input  logic                  mem_gnt_i,
  // control plane
  input  sink_pkg::sink_ctrl_t  ctrl_i,
  output sink_pkg::sink_flags_t flags_o
);

  logic                        gen_en, gen_clr, gen_done;
  logic                        busy, store_fire;
  logic                        addr_valid, addr_ready;   // generator to fifo
  logic [sink_pkg::ADDR_W-1:0] addr;
  logic                        head_valid, head_ready;   // fifo to aligner
  logic [sink_pkg::ADDR_W-1:0] head_addr;

  sink_ctrl u_sink_ctrl (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .enable_i     ( enable_i   ),
    .ctrl_i       ( ctrl_i     ),
    .gen_done_i   ( gen_done   ),
    .store_fire_i ( store_fire ),
    .gen_en_o     ( gen_en     ),
    .gen_clr_o    ( gen_clr    ),
    .busy_o       ( busy       ),
    .flags_o      ( flags_o    )
  );

  sink_addr_gen u_sink_addr_gen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .enable_i     ( enable_i   ),
    .gen_en_i     ( gen_en     ),
    .gen_clr_i    ( gen_clr    ),
    .cfg_i        ( ctrl_i.cfg ),   // held by the host for the job
    .addr_valid_o ( addr_valid ),
    .addr_o       ( addr       ),
    .addr_ready_i ( addr_ready ),
    .gen_done_o   ( gen_done   )
  );

  sink_addr_fifo u_sink_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( addr_valid ),
    .push_addr_i  ( addr       ),
    .push_ready_o ( addr_ready ),
    .pop_valid_o  ( head_valid ),
    .pop_addr_o   ( head_addr  ),
    .pop_ready_i  ( head_ready )
  );

  sink_store_align u_sink_store_align (
    .busy_i       ( busy         ),
    .addr_valid_i ( head_valid   ),
    .addr_i       ( head_addr    ),
    .addr_ready_o ( head_ready   ),
    .strm_valid_i ( strm_valid_i ),
    .strm_i       ( strm_i       ),
    .strm_ready_o ( strm_ready_o ),
    .mem_valid_o  ( mem_valid_o  ),
    .mem_o        ( mem_o        ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .store_fire_o ( store_fire   )
  );

endmodule

//--- logic/sink_ctrl.sv
// streamer control FSM, latches the job, counts granted stores and flags completion
`timescale 1ns/10ps

module sink_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  enable_i,
  input  sink_pkg::sink_ctrl_t  ctrl_i,
  input  logic                  gen_done_i,
  input  logic                  store_fire_i,
  output logic                  gen_en_o,
  output logic                  gen_clr_o,
  output logic                  busy_o,
  output sink_pkg::sink_flags_t flags_o
);

  sink_pkg::sink_state_e      state_q, state_d;
  sink_pkg::sink_cfg_t        cfg_q;            // job copy
  logic [sink_pkg::CNT_W-1:0] cnt_q, cnt_d;     // granted stores
  logic                       done_q;
  logic                       finish;           // last store granted this cycle
  logic                       start;

  assign start = (state_q == sink_pkg::SINK_IDLE) & ctrl_i.req_start;
  assign cnt_d = cnt_q + store_fire_i;

  // next count is checked so done lands the cycle right after the last grant
  always_comb begin
    state_d = state_q;
    finish  = 1'b0;
    case (state_q)
      sink_pkg::SINK_IDLE: begin
        if (ctrl_i.req_start) state_d = sink_pkg::SINK_WORKING;
      end
      sink_pkg::SINK_WORKING: begin
        // last grant can coincide with gen_done showing up
        if (gen_done_i) begin
          if (cnt_d == cfg_q.tot_len) begin
            finish  = 1'b1;
            state_d = sink_pkg::SINK_IDLE;
          end else begin
            state_d = sink_pkg::SINK_DRAIN;
          end
        end
      end
      sink_pkg::SINK_DRAIN: begin
        if (cnt_d == cfg_q.tot_len) begin   // wait for the tail stores
          finish  = 1'b1;
          state_d = sink_pkg::SINK_IDLE;
        end
      end
      default: state_d = sink_pkg::SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= sink_pkg::SINK_IDLE;
      cfg_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= sink_pkg::SINK_IDLE;
      cfg_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (enable_i) begin
      state_q <= state_d;
      done_q  <= finish;                    // one cycle pulse
      if (start) cfg_q <= ctrl_i.cfg;
      if (finish) begin
        cnt_q <= '0;                        // ready for the next job
      end else begin
        cnt_q <= cnt_d;
      end
    end
  end

  assign gen_en_o  = (state_q != sink_pkg::SINK_IDLE);
  assign gen_clr_o = finish & enable_i;     // rewind generator with the job
  assign busy_o    = enable_i & (state_q != sink_pkg::SINK_IDLE);

  assign flags_o.ready_start = (state_q == sink_pkg::SINK_IDLE);
  assign flags_o.done        = done_q;
  assign flags_o.gen_done    = gen_done_i;

endmodule

//--- logic/sink_store_align.sv
// store aligner, joins address head and stream beat and shifts them into the memory lane
`timescale 1ns/10ps

module sink_store_align (
  input  logic                        busy_i,         // job running, not frozen
  input  logic                        addr_valid_i,
  input  logic [sink_pkg::ADDR_W-1:0] addr_i,
  output logic                        addr_ready_o,
  input  logic                        strm_valid_i,
  input  sink_pkg::strm_beat_t        strm_i,
  output logic                        strm_ready_o,
  output logic                        mem_valid_o,
  output sink_pkg::mem_store_t        mem_o,
  input  logic                        mem_gnt_i,
  output logic                        store_fire_o    // one per accepted store
);

  logic [sink_pkg::OFFS_W-1:0] offs;     // byte offset in the word
  logic [sink_pkg::MEM_DW-1:0] data_wide;
  logic [sink_pkg::MEM_BE-1:0] be_wide;
  logic                        fire;

  assign offs = addr_i[sink_pkg::OFFS_W-1:0];

  // zero extend then shift, uncovered lanes stay zero
  assign data_wide = sink_pkg::MEM_DW'(strm_i.data);
  assign be_wide   = sink_pkg::MEM_BE'(strm_i.strb);

  always_comb begin
    mem_o      = '0;
    mem_o.addr = {addr_i[sink_pkg::ADDR_W-1:sink_pkg::OFFS_W], {sink_pkg::OFFS_W{1'b0}}};
    mem_o.data = data_wide << {offs, 3'b000};   // 8 bits per byte
    mem_o.be   = be_wide << offs;
  end

  // request only when both halves are here
  assign mem_valid_o = busy_i & addr_valid_i & strm_valid_i;
  assign fire        = mem_valid_o & mem_gnt_i;

  // both sides popped together on the grant, request held otherwise
  assign addr_ready_o = fire;
  assign strm_ready_o = fire;
  assign store_fire_o = fire;

endmodule

//--- logic/sink_addr_fifo.sv
// address buffer, small circular valid/ready FIFO between generator and aligner
`timescale 1ns/10ps

module sink_addr_fifo (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        push_valid_i,
  input  logic [sink_pkg::ADDR_W-1:0] push_addr_i,
  output logic                        push_ready_o,
  output logic                        pop_valid_o,
  output logic [sink_pkg::ADDR_W-1:0] pop_addr_o,
  input  logic                        pop_ready_i
);

  logic [sink_pkg::ADDR_W-1:0]     mem_q [sink_pkg::FIFO_DEPTH];
  logic [sink_pkg::FIFO_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [sink_pkg::FIFO_CNT_W-1:0] cnt_q;
  logic                            push, pop;

  assign push_ready_o = (cnt_q != sink_pkg::FIFO_CNT_W'(sink_pkg::FIFO_DEPTH));   // not full
  assign pop_valid_o  = (cnt_q != '0);                                            // not empty
  assign pop_addr_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // wrap at depth, not at pointer width
  function automatic logic [sink_pkg::FIFO_PTR_W-1:0] ptr_inc(
    input logic [sink_pkg::FIFO_PTR_W-1:0] ptr
  );
    if (ptr == sink_pkg::FIFO_PTR_W'(sink_pkg::FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + push - pop;   // both at once leaves it unchanged
    end
  end

  // storage, payload only
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_addr_i;
  end

endmodule

//--- logic/sink_addr_gen.sv
// 1-d address generator, one store address per handshake from base plus a byte stride
`timescale 1ns/10ps

module sink_addr_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        enable_i,
  input  logic                        gen_en_i,     // job running
  input  logic                        gen_clr_i,    // end of job
  input  sink_pkg::sink_cfg_t         cfg_i,
  output logic                        addr_valid_o,
  output logic [sink_pkg::ADDR_W-1:0] addr_o,
  input  logic                        addr_ready_i,
  output logic                        gen_done_o
);

  logic [sink_pkg::ADDR_W-1:0] offs_q;   // running byte offset from base
  logic [sink_pkg::CNT_W-1:0]  cnt_q;    // addresses issued so far
  logic                        done_q;
  logic                        last;     // counter already at tot_len
  logic                        hs;       // address taken by the fifo
  logic                        hs_last;  // taking the final address
  logic                        clr;

  assign clr     = clear_i | gen_clr_i;
  assign last    = (cnt_q == cfg_i.tot_len);
  assign hs      = addr_valid_o & addr_ready_i;
  assign hs_last = hs & ((cnt_q + 1'b1) == cfg_i.tot_len);

  // first address comes straight from base, no warm-up cycle
  assign addr_o       = cfg_i.base_addr + offs_q;
  assign addr_valid_o = enable_i & gen_en_i & ~done_q & ~last;
  assign gen_done_o   = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q <= '0;
      cnt_q  <= '0;
    end else if (clr) begin
      offs_q <= '0;
      cnt_q  <= '0;
    end else if (enable_i && hs) begin
      offs_q <= offs_q + sink_pkg::ADDR_W'(cfg_i.stride);   // stride is unsigned
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  // sticky until the controller clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clr) begin
      done_q <= 1'b0;
    end else if (enable_i && gen_en_i && (hs_last || last)) begin
      done_q <= 1'b1;   // last also covers a zero-length job
    end
  end

endmodule

//--- logic/sink_pkg.sv
// store streamer package with shared widths, channel structs and the control FSM state
package sink_pkg;

  // widths
  localparam int unsigned ADDR_W     = 32;             // byte address
  localparam int unsigned STRM_DW    = 32;             // stream word
  localparam int unsigned STRM_BE    = STRM_DW / 8;    // stream strobe
  localparam int unsigned MEM_DW     = STRM_DW + 32;   // widened for misaligned stores
  localparam int unsigned MEM_BE     = MEM_DW / 8;
  localparam int unsigned STRIDE_W   = 16;             // byte step
  localparam int unsigned CNT_W      = 16;             // word counter, max job 2^16-1
  localparam int unsigned OFFS_W     = 2;              // byte offset inside a word

  // address buffer
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // job configuration, 1-d pattern
  typedef struct packed {
    logic [ADDR_W-1:0]   base_addr;
    logic [STRIDE_W-1:0] stride;     // bytes between words
    logic [CNT_W-1:0]    tot_len;    // words in the job
  } sink_cfg_t;

  typedef struct packed {
    logic      req_start;
    sink_cfg_t cfg;
  } sink_ctrl_t;

  typedef struct packed {
    logic ready_start;   // idle, a start is taken
    logic done;          // one cycle after the last store
    logic gen_done;      // all addresses issued
  } sink_flags_t;

  // incoming stream beat
  typedef struct packed {
    logic [STRM_DW-1:0] data;
    logic [STRM_BE-1:0] strb;
  } strm_beat_t;

  // store request on the memory port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // word aligned
    logic [MEM_DW-1:0] data;
    logic [MEM_BE-1:0] be;
  } mem_store_t;

  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_WORKING,
    SINK_DRAIN
  } sink_state_e;

endpackage
